// ==== trs_io_pkg.sv ====
package trs_io_pkg;

  // command codes on the spi link, anything else is dropped by the parser
  typedef enum logic [7:0] {
    get_cookie    = 8'd0,
    bram_poke     = 8'd1,  // addr lo, addr hi, data
    bram_peek     = 8'd2,  // addr lo, addr hi, then one reply byte
    set_full_addr = 8'd14, // one flag byte
    get_version   = 8'd15
  } cmd_t;

  // identity
  localparam logic [7:0] COOKIE        = 8'haf;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // widths
  localparam int BUS_ADDR_W = 16; // z80 address bus
  localparam int RAM_ADDR_W = 15; // 32k bytes by default
  localparam int BYTE_W     = 8;

  // address mux select, which half of the bus shows up on trs_ah
  localparam logic [1:0] MUX_HIGH = 2'b01; // a15..a8
  localparam logic [1:0] MUX_LOW  = 2'b10; // a7..a0, also the idle value

  // memory windows
  localparam logic [BUS_ADDR_W-1:0] ROM_TOP       = 16'h3000; // rom below this, full mode only
  localparam logic [BUS_ADDR_W-1:0] RAM_FULL_BASE = 16'h4000; // ram from here up, full mode

  // board wiring of the high address byte
  // entry i is the trs_ah pin that carries address bit 8+i
  //   a8  <- pin 1   a9  <- pin 0
  //   a10 <- pin 2   a11 <- pin 3
  //   a12 <- pin 6   a13 <- pin 7
  //   a14 <- pin 4   a15 <- pin 5
  localparam logic [7:0][2:0] AH_PIN = {
    3'd5, // a15
    3'd4, // a14
    3'd7, // a13
    3'd6, // a12
    3'd3, // a11
    3'd2, // a10
    3'd0, // a9
    3'd1  // a8
  };

endpackage

// ==== dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram import trs_io_pkg::*; #(
  parameter int addr_w = RAM_ADDR_W,
  parameter int depth  = 1 << addr_w
) (
  input  logic              clk,
  input  logic              a_en,
  input  logic              a_we,
  input  logic [addr_w-1:0] a_addr,
  input  logic [BYTE_W-1:0] a_wdata,
  output logic [BYTE_W-1:0] a_rdata,
  input  logic              b_en,
  input  logic              b_we,
  input  logic [addr_w-1:0] b_addr,
  input  logic [BYTE_W-1:0] b_wdata,
  output logic [BYTE_W-1:0] b_rdata
);

  logic [BYTE_W-1:0] mem [depth]; // shared by both ports
  logic [BYTE_W-1:0] a_q, b_q;    // first read stage

  // read-first on both ports, port b wins a same-address write collision
  always_ff @(posedge clk) begin
    if (a_en && a_we) mem[a_addr] <= a_wdata;
    if (b_en && b_we) mem[b_addr] <= b_wdata;
    if (a_en) a_q <= mem[a_addr];
    if (b_en) b_q <= mem[b_addr];
    a_rdata <= a_q; // output register, data two clocks after en
    b_rdata <= b_q;
  end

endmodule

// ==== spi_command_port.sv ====
`timescale 1ns/1ps

module spi_command_port import trs_io_pkg::*; #(
  parameter int addr_w = RAM_ADDR_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              sck,
  input  logic              mosi,
  input  logic              cs_n,
  output logic              miso,
  output logic              b_en,
  output logic              b_we,
  output logic [addr_w-1:0] b_addr,
  output logic [BYTE_W-1:0] b_wdata,
  input  logic [BYTE_W-1:0] b_rdata,
  output logic              full_addr
);

  typedef enum logic {st_idle, st_params} state_t;

  logic [2:0] sck_s;  // two sync flops plus one for edge detect
  logic [2:0] cs_s;
  logic [1:0] mosi_s;

  logic [2:0]            bit_cnt;
  logic [BYTE_W-1:0]     shift_in;
  logic                  byte_rx;   // one pulse per accepted byte
  state_t                state;
  cmd_t                  cmd_q;
  logic [1:0]            params_left;
  logic [BUS_ADDR_W-1:0] addr_sr;   // param bytes shift in from the top
  logic [BUS_ADDR_W-1:0] peek_addr;

  logic              reply_req;  // a reply byte follows this command
  logic              id_load;    // cookie or version ready in id_byte
  logic [BYTE_W-1:0] id_byte;
  logic [1:0]        peek_dly;   // tracks the two clock ram read
  logic              reply_due;  // next falling edge opens the reply byte
  logic [3:0]        bits_left;
  logic [BYTE_W-1:0] out_q;

  wire sck_rise  = (sck_s[2:1] == 2'b01);
  wire sck_fall  = (sck_s[2:1] == 2'b10);
  wire cs_active = ~cs_s[1];
  wire cs_start  = (cs_s[2:1] == 2'b10); // falling edge of cs_n
  wire busy      = reply_due || (bits_left != 4'd0); // mosi ignored during a reply

  assign peek_addr = {shift_in, addr_sr[BUS_ADDR_W-1:BYTE_W]}; // hi byte just arrived
  assign miso      = cs_active & out_q[BYTE_W-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_s  <= '0;
      cs_s   <= '1; // deselected
      mosi_s <= '0;
    end else begin
      sck_s  <= {sck_s[1:0], sck};
      cs_s   <= {cs_s[1:0], cs_n};
      mosi_s <= {mosi_s[0], mosi};
    end
  end

  // bit counter and input shifter, msb first, sampled on rising sck
  always_ff @(posedge clk) begin
    if (rst || !cs_active || cs_start) begin
      bit_cnt <= '0;
      byte_rx <= 1'b0;
    end else begin
      byte_rx <= sck_rise && (bit_cnt == 3'd7) && !busy;
      if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        shift_in <= {shift_in[BYTE_W-2:0], mosi_s[1]};
      end
    end
  end

  // command parser, acts one clock after byte_rx
  always_ff @(posedge clk) begin
    b_en      <= 1'b0;
    reply_req <= 1'b0;
    id_load   <= 1'b0;
    if (rst) begin
      state       <= st_idle;
      params_left <= '0;
      b_we        <= 1'b0;
      full_addr   <= 1'b0;
    end else if (cs_start) begin
      state       <= st_idle; // new frame
      params_left <= '0;
    end else if (byte_rx) begin
      case (state)
        st_idle: begin
          cmd_q <= cmd_t'(shift_in);
          case (shift_in)
            get_cookie: begin
              id_byte   <= COOKIE;
              id_load   <= 1'b1;
              reply_req <= 1'b1;
            end
            get_version: begin
              id_byte   <= {VERSION_MAJOR, VERSION_MINOR}; // 03 hex
              id_load   <= 1'b1;
              reply_req <= 1'b1;
            end
            bram_poke: begin
              state       <= st_params;
              params_left <= 2'd3;
            end
            bram_peek: begin
              state       <= st_params;
              params_left <= 2'd2;
            end
            set_full_addr: begin
              state       <= st_params;
              params_left <= 2'd1;
            end
            default: ; // unknown code, stay idle
          endcase
        end
        st_params: begin
          addr_sr     <= {shift_in, addr_sr[BUS_ADDR_W-1:BYTE_W]};
          params_left <= params_left - 2'd1;
          if (params_left == 2'd1) begin // last parameter, execute
            state <= st_idle;
            case (cmd_q)
              bram_poke: begin
                b_en    <= 1'b1;
                b_we    <= 1'b1;
                b_addr  <= addr_sr[addr_w-1:0]; // lo and hi already in
                b_wdata <= shift_in;
              end
              bram_peek: begin
                b_en      <= 1'b1;
                b_we      <= 1'b0;
                b_addr    <= peek_addr[addr_w-1:0];
                reply_req <= 1'b1;
              end
              set_full_addr: full_addr <= (shift_in != '0);
              default: ;
            endcase
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // reply shifter, changes on falling sck
  always_ff @(posedge clk) begin
    if (rst || cs_start) begin
      peek_dly  <= '0;
      reply_due <= 1'b0;
      bits_left <= '0;
      out_q     <= '0;
    end else begin
      peek_dly <= {peek_dly[0], b_en & ~b_we};
      if (reply_req) reply_due <= 1'b1;
      if (sck_fall && cs_active) begin
        if (reply_due) begin
          reply_due <= 1'b0; // msb already on miso, hold it this edge
          bits_left <= 4'd8;
        end else if (bits_left != 4'd0) begin
          out_q     <= {out_q[BYTE_W-2:0], 1'b0};
          bits_left <= bits_left - 4'd1;
        end
      end
      if (id_load) out_q <= id_byte;
      else if (peek_dly[1]) out_q <= b_rdata; // ram data valid now
    end
  end

endmodule

// ==== z80_bus_port.sv ====
`timescale 1ns/1ps

module z80_bus_port import trs_io_pkg::*; #(
  parameter int addr_w     = RAM_ADDR_W,
  parameter int filter_len = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_n,
  input  logic              wr_n,
  input  logic              in_n,
  input  logic              out_n,
  input  logic [BYTE_W-1:0] trs_ah,
  output logic [1:0]        mux_a,
  input  logic [BYTE_W-1:0] trs_d_in,
  output logic [BYTE_W-1:0] trs_d_out,
  output logic              trs_d_oe,
  output logic              trs_oe_n,
  input  logic              full_addr,
  output logic              a_en,
  output logic              a_we,
  output logic [addr_w-1:0] a_addr,
  output logic [BYTE_W-1:0] a_wdata,
  input  logic [BYTE_W-1:0] a_rdata
);

  localparam int cnt_w = $clog2(filter_len + 1);

  logic [1:0]            strb_s;   // synchronizer on the combined strobe
  logic [cnt_w-1:0]      flt_cnt;
  logic                  acc;      // filtered access
  logic                  acc_d;
  logic [8:1]            stage_q;  // capture sequence, bit k is cycle k
  logic [8:0]            stage;
  logic [BUS_ADDR_W-1:0] addr_q;
  logic                  addr_valid;
  logic [BYTE_W-1:0]     ah_unswap;
  logic                  ram_sel, rom_sel;
  logic                  rd_req, wr_pend;
  logic [1:0]            rd_dly;
  logic                  rd_hold;

  wire strb_raw = ~rd_n | ~wr_n | ~in_n | ~out_n;

  assign stage = {stage_q, acc & ~acc_d}; // stage[0] is the rising edge
  assign mux_a = (stage[3:0] != '0) ? MUX_HIGH : MUX_LOW;

  // undo the board swap on the high byte
  always_comb begin
    for (int i = 0; i < BYTE_W; i++) ah_unswap[i] = trs_ah[AH_PIN[i]];
  end

  // window decode
  always_comb begin
    if (full_addr) begin
      ram_sel = addr_valid && (addr_q >= RAM_FULL_BASE);
      rom_sel = addr_valid && (addr_q < ROM_TOP);
    end else begin
      ram_sel = addr_valid && addr_q[BUS_ADDR_W-1]; // upper 32k only
      rom_sel = 1'b0;
    end
  end

  assign rd_req   = stage[8] && !rd_n && (ram_sel || rom_sel);
  assign trs_oe_n = ~((ram_sel || rom_sel) && (!rd_n || !wr_n));
  assign trs_d_oe = rd_hold & ~rd_n; // drop at once when rd_n rises
  assign a_addr   = addr_q[addr_w-1:0];

  // strobe filter, level must hold filter_len clocks before it counts
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_s  <= '0;
      flt_cnt <= '0;
      acc     <= 1'b0;
      acc_d   <= 1'b0;
    end else begin
      strb_s <= {strb_s[0], strb_raw};
      acc_d  <= acc;
      if (strb_s[1] == acc) begin
        flt_cnt <= '0;
      end else if (flt_cnt == cnt_w'(filter_len - 1)) begin
        acc     <= strb_s[1];
        flt_cnt <= '0;
      end else begin
        flt_cnt <= flt_cnt + 1'b1;
      end
    end
  end

  // two phase address capture
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_q    <= '0;
      addr_valid <= 1'b0;
    end else begin
      stage_q <= stage[7:0];
      if (stage[7]) addr_valid <= 1'b1;
      else if (stage[3] || !acc) addr_valid <= 1'b0;
    end
    if (stage[3]) addr_q[BUS_ADDR_W-1:BYTE_W] <= ah_unswap;
    if (stage[7]) addr_q[BYTE_W-1:0] <= trs_ah;
  end

  // port a, read enable at cycle 9, write at cycle 10, data out at 11
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pend <= 1'b0;
      a_en    <= 1'b0;
      a_we    <= 1'b0;
      rd_dly  <= '0;
      rd_hold <= 1'b0;
    end else begin
      wr_pend <= stage[8] && !wr_n && ram_sel; // no writes into rom
      a_en    <= rd_req || wr_pend;
      a_we    <= wr_pend;
      rd_dly  <= {rd_dly[0], a_en & ~a_we};
      if (rd_dly[1]) rd_hold <= 1'b1;
      else if (!acc) rd_hold <= 1'b0;
    end
    if (wr_pend) a_wdata <= trs_d_in;
    if (rd_dly[1]) trs_d_out <= a_rdata;
  end

endmodule

// ==== trs_io_top.sv ====
`timescale 1ns/1ps

module trs_io_top import trs_io_pkg::*; #(
  parameter int addr_w     = RAM_ADDR_W,
  parameter int filter_len = 4
) (
  input  logic              clk,
  input  logic              rst,
  // spi link from the microcontroller
  input  logic              sck,
  input  logic              mosi,
  input  logic              cs_n,
  output logic              miso,
  // z80 bus
  input  logic              rd_n,
  input  logic              wr_n,
  input  logic              in_n,
  input  logic              out_n,
  input  logic [BYTE_W-1:0] trs_ah,
  output logic [1:0]        mux_a,
  input  logic [BYTE_W-1:0] trs_d_in,
  output logic [BYTE_W-1:0] trs_d_out,
  output logic              trs_d_oe,
  output logic              trs_oe_n
);

  logic              full_addr;
  logic              a_en, a_we, b_en, b_we;
  logic [addr_w-1:0] a_addr, b_addr;
  logic [BYTE_W-1:0] a_wdata, a_rdata, b_wdata, b_rdata;

  spi_command_port #(.addr_w(addr_w)) u_spi (
    .clk(clk), .rst(rst),
    .sck(sck), .mosi(mosi), .cs_n(cs_n), .miso(miso),
    .b_en(b_en), .b_we(b_we), .b_addr(b_addr), .b_wdata(b_wdata), .b_rdata(b_rdata),
    .full_addr(full_addr)
  );

  z80_bus_port #(.addr_w(addr_w), .filter_len(filter_len)) u_bus (
    .clk(clk), .rst(rst),
    .rd_n(rd_n), .wr_n(wr_n), .in_n(in_n), .out_n(out_n),
    .trs_ah(trs_ah), .mux_a(mux_a),
    .trs_d_in(trs_d_in), .trs_d_out(trs_d_out), .trs_d_oe(trs_d_oe), .trs_oe_n(trs_oe_n),
    .full_addr(full_addr),
    .a_en(a_en), .a_we(a_we), .a_addr(a_addr), .a_wdata(a_wdata), .a_rdata(a_rdata)
  );

  // port a serves the z80, port b the spi side
  dual_port_ram #(.addr_w(addr_w), .depth(1 << addr_w)) u_ram (
    .clk(clk),
    .a_en(a_en), .a_we(a_we), .a_addr(a_addr), .a_wdata(a_wdata), .a_rdata(a_rdata),
    .b_en(b_en), .b_we(b_we), .b_addr(b_addr), .b_wdata(b_wdata), .b_rdata(b_rdata)
  );

endmodule

// ==== tb_trs_io.sv ====
`timescale 1ns/1ps

module tb_trs_io import trs_io_pkg::*; ();

  localparam logic [31:0] lfsr_seed = 32'h46b1d432;
  localparam int n_commands = 35;  // spi frames plus z80 accesses
  localparam int frame_clks = 400; // longest frame is a poke with cs gaps
  localparam int timeout_ns = n_commands * frame_clks * 8 + 2000;

  logic clk, rst, sck, mosi, cs_n;
  logic rd_n, wr_n, in_n, out_n;
  logic [7:0] trs_ah, trs_d_in;
  wire miso, trs_d_oe, trs_oe_n;
  wire [1:0] mux_a;
  wire [7:0] trs_d_out;

  logic [31:0] lfsr;
  int errors;

  trs_io_top #(.addr_w(RAM_ADDR_W), .filter_len(4)) DUT (
    .clk(clk), .rst(rst), .sck(sck), .mosi(mosi), .cs_n(cs_n), .miso(miso),
    .rd_n(rd_n), .wr_n(wr_n), .in_n(in_n), .out_n(out_n),
    .trs_ah(trs_ah), .mux_a(mux_a), .trs_d_in(trs_d_in),
    .trs_d_out(trs_d_out), .trs_d_oe(trs_d_oe), .trs_oe_n(trs_oe_n)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk; // 8 ns

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // address bit 8+i lands on pin AH_PIN[i]
  function automatic logic [7:0] wire_high(input logic [7:0] hi);
    logic [7:0] pins;
    pins = '0;
    for (int i = 0; i < 8; i++) pins[AH_PIN[i]] = hi[i];
    return pins;
  endfunction

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp_data);
    assert (got === exp_data) else begin
      $display("MISMATCH at %0t ns: %s got %02h, expected %02h", $time, what, got, exp_data);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic ok);
    assert (ok === 1'b1) else begin
      $display("MISMATCH at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic check_arrived(input string what, input logic ok);
    assert (ok === 1'b1) else begin
      $display("%s did not happen in time, at %0t ns", what, $time);
      errors++;
    end
  endtask

  // mode 0 msb first with a half period of 6 clocks
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    rx = '0;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (6) @(negedge clk);
      sck   = 1'b1;
      rx[i] = miso; // master samples on the rise
      repeat (6) @(negedge clk);
      sck = 1'b0;
    end
  endtask

  task automatic spi_begin();
    cs_n = 1'b0;
    repeat (6) @(negedge clk); // let cs_n through the synchronizer
  endtask

  task automatic spi_end();
    repeat (2) @(negedge clk);
    cs_n = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  // one byte command with the reply in the following byte
  task automatic spi_read_id(input logic [7:0] code, output logic [7:0] val);
    logic [7:0] ignored;
    spi_begin();
    spi_byte(code, ignored);
    spi_byte(8'h00, val);
    spi_end();
  endtask

  task automatic spi_poke(input logic [14:0] addr, input logic [7:0] data);
    logic [7:0] ignored;
    spi_begin();
    spi_byte(bram_poke, ignored);
    spi_byte(addr[7:0], ignored);
    spi_byte({1'b0, addr[14:8]}, ignored);
    spi_byte(data, ignored);
    spi_end();
  endtask

  task automatic spi_peek(input logic [14:0] addr, output logic [7:0] data);
    logic [7:0] ignored;
    spi_begin();
    spi_byte(bram_peek, ignored);
    spi_byte(addr[7:0], ignored);
    spi_byte({1'b0, addr[14:8]}, ignored);
    spi_byte(8'h00, data); // reply byte
    spi_end();
  endtask

  task automatic spi_set_full(input logic [7:0] flag);
    logic [7:0] ignored;
    spi_begin();
    spi_byte(set_full_addr, ignored);
    spi_byte(flag, ignored);
    spi_end();
  endtask

  // memory access with trs_ah following mux_a
  // selected only matters for reads
  task automatic z80_access(input logic write, input logic [15:0] addr, input logic [7:0] wdata,
                            input logic selected, input logic [7:0] exp_data);
    int cnt;
    logic done;
    trs_ah   = addr[7:0];
    trs_d_in = wdata;
    if (write) wr_n = 1'b0;
    else rd_n = 1'b0;
    cnt = 0;
    while (mux_a !== MUX_HIGH && cnt < 20) begin // wait for cycle 0 of the filtered access
      @(negedge clk);
      cnt++;
    end
    check_arrived("high address phase on mux_a", mux_a === MUX_HIGH);
    cnt  = 0;
    done = 1'b0;
    while (!done) begin
      trs_ah = (mux_a === MUX_HIGH) ? wire_high(addr[15:8]) : addr[7:0];
      if (!write && selected && trs_d_oe === 1'b1) done = 1'b1;
      else if ((write || !selected) && cnt == 14) done = 1'b1; // past cycle 10
      else if (cnt == 24) done = 1'b1;
      else begin
        if (!write && !selected) check_flag("trs_oe_n low on unselected read", trs_oe_n);
        @(negedge clk);
        cnt++;
      end
    end
    if (!write && selected) begin
      check_arrived("read data enable", trs_d_oe === 1'b1);
      // byte is loaded at the end of cycle 11
      check_flag("read data not out right after the cycle 11 load", cnt == 12);
      check_byte("trs_d_out", trs_d_out, exp_data);
      check_flag("trs_oe_n high during selected read", trs_oe_n === 1'b0);
    end else if (!write) begin
      check_flag("trs_d_oe high on unselected read", trs_d_oe === 1'b0);
    end
    rd_n = 1'b1;
    wr_n = 1'b1;
    repeat (12) @(negedge clk); // strobe end goes through the filter too
  endtask

  // watchdog
  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns, the tests did not complete", timeout_ns);
    $display("errors: %0d", errors);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0] r, d;
    logic [7:0]  got, keep;
    lfsr   = lfsr_seed;
    errors = 0;
    rst = 1'b1;
    sck = 1'b0;
    mosi = 1'b0;
    cs_n = 1'b1;
    rd_n = 1'b1;
    wr_n = 1'b1;
    in_n = 1'b1;
    out_n = 1'b1;
    trs_ah = '0;
    trs_d_in = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // reset state and identity
    check_flag("miso not low after reset", miso === 1'b0);
    check_flag("trs_oe_n not high after reset", trs_oe_n === 1'b1);
    check_flag("mux_a not MUX_LOW after reset", mux_a === MUX_LOW);
    check_flag("trs_d_oe not low after reset", trs_d_oe === 1'b0);
    spi_read_id(get_cookie, got);
    check_byte("cookie", got, COOKIE);
    spi_read_id(get_version, got);
    check_byte("version", got, 8'h03);

    // poke then peek
    for (int n = 0; n < 6; n++) begin
      take_bits(15, r);
      take_bits(8, d);
      spi_poke(r[14:0], d[7:0]);
      spi_peek(r[14:0], got);
      check_byte("peek after poke", got, d[7:0]);
    end

    // spi poke then z80 read from the upper 32k
    for (int n = 0; n < 3; n++) begin
      take_bits(15, r);
      take_bits(8, d);
      spi_poke(r[14:0], d[7:0]);
      z80_access(1'b0, {1'b1, r[14:0]}, 8'h00, 1'b1, d[7:0]);
    end

    // z80 write through the swapped high byte then spi peek
    for (int n = 0; n < 3; n++) begin
      take_bits(15, r);
      take_bits(8, d);
      z80_access(1'b1, {1'b1, r[14:0]}, d[7:0], 1'b1, 8'h00);
      spi_peek(r[14:0], got);
      check_byte("peek after z80 write", got, d[7:0]);
    end

    // windows at 1000 hex
    take_bits(8, d);
    keep = d[7:0];
    spi_poke(15'h1000, keep);
    z80_access(1'b0, 16'h1000, 8'h00, 1'b0, 8'h00); // low 32k is unselected
    spi_set_full(8'h01);
    z80_access(1'b0, 16'h1000, 8'h00, 1'b1, keep);  // rom window reads ram
    z80_access(1'b1, 16'h1000, ~keep, 1'b1, 8'h00); // rom window drops the write
    spi_peek(15'h1000, got);
    check_byte("byte at 1000 after rom write", got, keep);
    spi_set_full(8'h00);
    z80_access(1'b0, 16'h1000, 8'h00, 1'b0, 8'h00);

    $display("errors: %0d", errors);
    if (errors == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  end

endmodule

// ==== src.f ====
trs_io_pkg.sv
dual_port_ram.sv
spi_command_port.sv
z80_bus_port.sv
trs_io_top.sv
tb_trs_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_trs_io -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
  echo "run_sim: simulation passed"
  exit 0
else
  echo "run_sim: simulation failed"
  exit 1
fi
